// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - core_pkg.sv
  - fetch.sv
  - id_stage.sv
  - ex_stage.sv
  - regs.sv
  - ctrl.sv
  - core.sv
  - target: test
    files:
      - core_asserts.sv
      - tb_core.sv

// ==== core.sv ====
/*
 * Top level of the pipeline core. Connects fetch, decode, execute, the
 * register file and control, and exposes the instruction and data memory
 * ports. Both memories sit outside and answer in the same cycle.
 */
module core import core_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic [XLEN-1:0] instr_i,
	input  logic [XLEN-1:0] data_mem_i,
	output logic [XLEN-1:0] pc_o,
	output logic            instr_rd_en_o,
	output logic            mem_state_o,
	output logic [XLEN-1:0] addr_mem_o,
	output logic [XLEN-1:0] data_mem_wr_o
);

	hold_e           hold;
	jmp_req_t        jmp_req;
	instr_u          instr;
	logic [4:0]      rs1_addr;
	logic [4:0]      rs2_addr;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] br_rs1;
	logic [XLEN-1:0] br_rs2;
	jmp_flag_e       jmp_flag;
	logic [XLEN-1:0] jmp_target;
	logic            load_hazard;
	id_ex_t          id_ex;
	wb_t             ex_fwd;
	wb_t             wb;

	fetch #(
		.RESET_PC(RESET_PC)
	) core_fetch (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.hold_i       (hold),
		.jmp_i        (jmp_req),
		.instr_i      (instr_i),
		.pc_o         (pc_o),
		.instr_o      (instr),
		.instr_rd_en_o(instr_rd_en_o)
	);

	id_stage core_id (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.hold_i       (hold),
		.instr_i      (instr),
		.pc_i         (pc_o),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.ex_fwd_i     (ex_fwd),
		.rs1_addr_o   (rs1_addr),
		.rs2_addr_o   (rs2_addr),
		.br_rs1_o     (br_rs1),
		.br_rs2_o     (br_rs2),
		.jmp_flag_o   (jmp_flag),
		.jmp_target_o (jmp_target),
		.load_hazard_o(load_hazard),
		.id_ex_o      (id_ex)
	);

	ex_stage core_ex (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.id_ex_i      (id_ex),
		.data_mem_i   (data_mem_i),
		.alu_fwd_o    (ex_fwd),
		.mem_state_o  (mem_state_o),
		.addr_mem_o   (addr_mem_o),
		.data_mem_wr_o(data_mem_wr_o),
		.wb_o         (wb)
	);

	regs core_regs (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.wb_i      (wb),
		.rs1_addr_i(rs1_addr),
		.rs2_addr_i(rs2_addr),
		.rs1_data_o(rs1_data),
		.rs2_data_o(rs2_data)
	);

	ctrl core_ctrl (
		.br_rs1_i     (br_rs1),
		.br_rs2_i     (br_rs2),
		.jmp_flag_i   (jmp_flag),
		.jmp_target_i (jmp_target),
		.load_hazard_i(load_hazard),
		.hold_o       (hold),
		.jmp_o        (jmp_req)
	);

endmodule

// ==== core_asserts.sv ====
/*
 * Concurrent checks on the core top level, bound into every core instance.
 */
module core_asserts (
	input logic        clk,
	input logic        arst_n_i,
	input logic [31:0] pc_i,
	input logic        instr_rd_en_i,
	input logic        mem_state_i
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	strobe_known: assert property (@(posedge clk) disable iff (!arst_n_i)
			!$isunknown(mem_state_i))
		else begin
			fail_count++;
			$error("store strobe is unknown");
		end

	pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i) pc_i[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("pc is not word aligned");
		end

	// a stall sends a bubble into EX, so the held store cannot strobe twice.
	no_double_store: assert property (@(posedge clk) disable iff (!arst_n_i)
			!instr_rd_en_i |=> !mem_state_i)
		else begin
			fail_count++;
			$error("store strobe repeated across a held PC");
		end

endmodule

bind core core_asserts core_checks (
	.clk          (clk),
	.arst_n_i     (arst_n_i),
	.pc_i         (pc_o),
	.instr_rd_en_i(instr_rd_en_o),
	.mem_state_i  (mem_state_o)
);

// ==== core_pkg.sv ====
/*
 * Shared definitions for the RV32I subset pipeline core.
 * Holds opcodes, the instruction format union, the stage bundles and the
 * hold codes that ctrl sends to the stages. Compile before any core module.
 */
package core_pkg;

	localparam int XLEN = 32;

	localparam logic [6:0] OP_R      = 7'b0110011;
	localparam logic [6:0] OP_I      = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;

	// addi x0, x0, 0
	localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		j_fmt_t j;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL
	} alu_op_e;

	typedef enum logic [1:0] {
		JMP_NONE,
		JMP_BEQ,
		JMP_BNE,
		JMP_JAL
	} jmp_flag_e;

	// stall holds PC and ID while a bubble enters EX; flush drops a fetched word.
	typedef enum logic [1:0] {
		HOLD_RUN,
		HOLD_STALL,
		HOLD_FLUSH
	} hold_e;

	typedef struct packed {
		alu_op_e         alu_op;
		logic [XLEN-1:0] op1;
		logic [XLEN-1:0] op2;
		logic [XLEN-1:0] store_data;
		logic [4:0]      rd;
		logic            reg_wr_en;
		logic            is_load;
		logic            is_store;
	} id_ex_t;

	typedef struct packed {
		logic            wr_en;
		logic [4:0]      addr;
		logic [XLEN-1:0] data;
	} wb_t;

	typedef struct packed {
		logic            en;
		logic [XLEN-1:0] target;
	} jmp_req_t;

endpackage

// ==== ctrl.sv ====
/*
 * Pipeline control. Resolves branches and JAL from the bypassed operands
 * that decode supplies, and picks the hold code for the stages.
 * Purely combinational.
 */
module ctrl import core_pkg::*; (
	input  logic [XLEN-1:0] br_rs1_i,
	input  logic [XLEN-1:0] br_rs2_i,
	input  jmp_flag_e       jmp_flag_i,
	input  logic [XLEN-1:0] jmp_target_i,
	input  logic            load_hazard_i,
	output hold_e           hold_o,
	output jmp_req_t        jmp_o
);

	logic equal;
	logic taken;

	assign equal = (br_rs1_i == br_rs2_i);

	always_comb begin
		case (jmp_flag_i)
			JMP_BEQ: taken = equal;
			JMP_BNE: taken = !equal;
			JMP_JAL: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// a stall wins over a jump, the branch is decided again once the load data is in WB.
	always_comb begin
		jmp_o.target = jmp_target_i;
		if (load_hazard_i) begin
			hold_o   = HOLD_STALL;
			jmp_o.en = 1'b0;
		end else if (taken) begin
			hold_o   = HOLD_FLUSH;
			jmp_o.en = 1'b1;
		end else begin
			hold_o   = HOLD_RUN;
			jmp_o.en = 1'b0;
		end
	end

endmodule

// ==== ex_stage.sv ====
/*
 * Execute stage with memory access. Runs the ALU on the registered bundle,
 * uses the sum as the data memory address, and registers the writeback.
 * The unregistered ALU result is offered back to decode for bypass.
 */
module ex_stage import core_pkg::*; (
	input  logic            clk,
	input  logic            arst_n_i,
	input  id_ex_t          id_ex_i,
	input  logic [XLEN-1:0] data_mem_i,
	output wb_t             alu_fwd_o,
	output logic            mem_state_o,
	output logic [XLEN-1:0] addr_mem_o,
	output logic [XLEN-1:0] data_mem_wr_o,
	output wb_t             wb_o
);

	logic [XLEN-1:0] alu_res;
	wb_t             wb_d;
	wb_t             wb_q;

	always_comb begin
		case (id_ex_i.alu_op)
			ALU_ADD: alu_res = id_ex_i.op1 + id_ex_i.op2;
			ALU_SUB: alu_res = id_ex_i.op1 - id_ex_i.op2;
			ALU_AND: alu_res = id_ex_i.op1 & id_ex_i.op2;
			ALU_OR:  alu_res = id_ex_i.op1 | id_ex_i.op2;
			ALU_XOR: alu_res = id_ex_i.op1 ^ id_ex_i.op2;
			ALU_SLL: alu_res = id_ex_i.op1 << id_ex_i.op2[4:0];
			ALU_SRL: alu_res = id_ex_i.op1 >> id_ex_i.op2[4:0];
			default: alu_res = id_ex_i.op1 + id_ex_i.op2;
		endcase
	end

	// a load result is not ready to forward here, ctrl stalls the consumer instead.
	assign alu_fwd_o.wr_en = id_ex_i.reg_wr_en && !id_ex_i.is_load;
	assign alu_fwd_o.addr  = id_ex_i.rd;
	assign alu_fwd_o.data  = alu_res;

	assign mem_state_o   = id_ex_i.is_store;
	assign addr_mem_o    = alu_res;
	assign data_mem_wr_o = id_ex_i.store_data;

	assign wb_d.wr_en = id_ex_i.reg_wr_en;
	assign wb_d.addr  = id_ex_i.rd;
	assign wb_d.data  = id_ex_i.is_load ? data_mem_i : alu_res;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_q <= '0;
		end else begin
			wb_q <= wb_d;
		end
	end

	assign wb_o = wb_q;

endmodule

// ==== fetch.sv ====
/*
 * Program counter and fetch. The PC addresses the instruction memory
 * directly and the word comes back in the same cycle; a redirect from ctrl
 * loads the target and the word seen in the following cycle is discarded.
 */
module fetch import core_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk,
	input  logic            arst_n_i,
	input  hold_e           hold_i,
	input  jmp_req_t        jmp_i,
	input  logic [XLEN-1:0] instr_i,
	output logic [XLEN-1:0] pc_o,
	output instr_u          instr_o,
	output logic            instr_rd_en_o
);

	logic [XLEN-1:0] pc_q;
	logic            mask_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q   <= RESET_PC;
			mask_q <= 1'b0;
		end else begin
			mask_q <= (hold_i == HOLD_FLUSH);
			if (jmp_i.en) begin
				pc_q <= jmp_i.target;
			end else if (hold_i != HOLD_STALL && !mask_q) begin
				pc_q <= pc_q + XLEN'(4);
			end
		end
	end

	// the masked cycle keeps the PC on the target, so the target is fetched again.
	assign pc_o          = pc_q;
	assign instr_o       = mask_q ? INSTR_NOP : instr_i;
	assign instr_rd_en_o = (hold_i != HOLD_STALL);

endmodule

// ==== files.f ====
core_pkg.sv
fetch.sv
id_stage.sv
ex_stage.sv
regs.sv
ctrl.sv
core.sv
core_asserts.sv
tb_core.sv

// ==== id_stage.sv ====
/*
 * Decode stage. Splits the instruction word through the format union,
 * builds immediates, bypasses operands from EX ahead of the register file
 * and registers the decoded bundle for EX. Branch operands go to ctrl.
 */
module id_stage import core_pkg::*; (
	input  logic            clk,
	input  logic            arst_n_i,
	input  hold_e           hold_i,
	input  instr_u          instr_i,
	input  logic [XLEN-1:0] pc_i,
	input  logic [XLEN-1:0] rs1_data_i,
	input  logic [XLEN-1:0] rs2_data_i,
	input  wb_t             ex_fwd_i,
	output logic [4:0]      rs1_addr_o,
	output logic [4:0]      rs2_addr_o,
	output logic [XLEN-1:0] br_rs1_o,
	output logic [XLEN-1:0] br_rs2_o,
	output jmp_flag_e       jmp_flag_o,
	output logic [XLEN-1:0] jmp_target_o,
	output logic            load_hazard_o,
	output id_ex_t          id_ex_o
);

	logic [6:0]      opcode;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [4:0]      rd;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;
	logic            use_rs1;
	logic            use_rs2;
	id_ex_t          id_ex_d;
	id_ex_t          id_ex_q;

	function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic sub);
		case (funct3)
			3'b000:  return sub ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b100:  return ALU_XOR;
			3'b101:  return ALU_SRL;
			3'b110:  return ALU_OR;
			3'b111:  return ALU_AND;
			default: return ALU_ADD;
		endcase
	endfunction

	// the live EX result wins; the register file already passes WB data through.
	function automatic logic [XLEN-1:0] bypass(input logic [4:0] addr,
			input logic [XLEN-1:0] rf_data, input wb_t fwd);
		if (addr != 5'd0 && fwd.wr_en && fwd.addr == addr) begin
			return fwd.data;
		end
		return rf_data;
	endfunction

	assign opcode = instr_i.r.opcode;
	assign rs1    = instr_i.r.rs1;
	assign rs2    = instr_i.r.rs2;
	assign rd     = instr_i.r.rd;

	assign imm_i = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
	assign imm_s = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5, instr_i.s.imm_4_0};
	assign imm_b = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
			instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
	assign imm_j = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
			instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

	assign rs1_addr_o = rs1;
	assign rs2_addr_o = rs2;
	assign rs1_val    = bypass(rs1, rs1_data_i, ex_fwd_i);
	assign rs2_val    = bypass(rs2, rs2_data_i, ex_fwd_i);
	assign br_rs1_o   = rs1_val;
	assign br_rs2_o   = rs2_val;

	assign jmp_target_o = pc_i + ((opcode == OP_JAL) ? imm_j : imm_b);

	always_comb begin
		id_ex_d            = '0;
		id_ex_d.alu_op     = ALU_ADD;
		id_ex_d.op1        = rs1_val;
		id_ex_d.op2        = rs2_val;
		id_ex_d.store_data = rs2_val;
		id_ex_d.rd         = rd;
		jmp_flag_o         = JMP_NONE;
		use_rs1            = 1'b0;
		use_rs2            = 1'b0;
		case (opcode)
			OP_R: begin
				id_ex_d.alu_op    = alu_decode(instr_i.r.funct3, instr_i.r.funct7[5]);
				id_ex_d.reg_wr_en = 1'b1;
				use_rs1           = 1'b1;
				use_rs2           = 1'b1;
			end
			OP_I: begin
				id_ex_d.alu_op    = alu_decode(instr_i.i.funct3, 1'b0);
				id_ex_d.op2       = imm_i;
				id_ex_d.reg_wr_en = 1'b1;
				use_rs1           = 1'b1;
			end
			OP_LOAD: begin
				id_ex_d.op2       = imm_i;
				id_ex_d.reg_wr_en = 1'b1;
				id_ex_d.is_load   = 1'b1;
				use_rs1           = 1'b1;
			end
			OP_STORE: begin
				id_ex_d.op2      = imm_s;
				id_ex_d.is_store = 1'b1;
				use_rs1          = 1'b1;
				use_rs2          = 1'b1;
			end
			OP_BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				if (instr_i.b.funct3 == 3'b000) begin
					jmp_flag_o = JMP_BEQ;
				end else if (instr_i.b.funct3 == 3'b001) begin
					jmp_flag_o = JMP_BNE;
				end
			end
			OP_JAL: begin
				// link value rides through the adder with a zero operand.
				id_ex_d.op1       = pc_i + XLEN'(4);
				id_ex_d.op2       = '0;
				id_ex_d.reg_wr_en = 1'b1;
				jmp_flag_o        = JMP_JAL;
			end
			default: ;
		endcase
		if (rd == 5'd0) begin
			id_ex_d.reg_wr_en = 1'b0;
		end
	end

	assign load_hazard_o = id_ex_q.is_load && id_ex_q.rd != 5'd0 &&
			((use_rs1 && id_ex_q.rd == rs1) || (use_rs2 && id_ex_q.rd == rs2));

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_ex_q <= '0;
		end else if (hold_i == HOLD_STALL) begin
			id_ex_q           <= id_ex_d;
			id_ex_q.reg_wr_en <= 1'b0;
			id_ex_q.is_load   <= 1'b0;
			id_ex_q.is_store  <= 1'b0;
		end else begin
			id_ex_q <= id_ex_d;
		end
	end

	assign id_ex_o = id_ex_q;

endmodule

// ==== regs.sv ====
/*
 * General register file, 32 by 32 bits, two read ports and one write port.
 * x0 always reads zero; a read of the register being written returns the
 * new value, so decode sees writeback data in the same cycle.
 */
module regs import core_pkg::*; (
	input  logic            clk,
	input  logic            arst_n_i,
	input  wb_t             wb_i,
	input  logic [4:0]      rs1_addr_i,
	input  logic [4:0]      rs2_addr_i,
	output logic [XLEN-1:0] rs1_data_o,
	output logic [XLEN-1:0] rs2_data_o
);

	logic [XLEN-1:0] rf_q [1:31];

	function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0) begin
			return '0;
		end else if (wb_i.wr_en && wb_i.addr == addr) begin
			return wb_i.data;
		end
		return rf_q[addr];
	endfunction

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				rf_q[i] <= '0;
			end
		end else if (wb_i.wr_en && wb_i.addr != 5'd0) begin
			rf_q[wb_i.addr] <= wb_i.data;
		end
	end

	assign rs1_data_o = read_port(rs1_addr_i);
	assign rs2_data_o = read_port(rs2_addr_i);

endmodule

// ==== tb_core.sv ====
/*
 * Directed testbench for the pipeline core. Models the instruction ROM and the
 * data RAM, assembles one short program per test and checks the stores it makes.
 */
module tb_core;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] RESET_PC  = 32'h0000_0040;
	localparam logic [11:0] MARK_ADDR = 12'h3fc;
	localparam logic [11:0] POISON    = 12'h5ad;
	localparam logic [2:0]  F_ADD     = 3'b000;
	localparam logic [2:0]  F_SLL     = 3'b001;
	localparam logic [2:0]  F_XOR     = 3'b100;
	localparam logic [2:0]  F_SRL     = 3'b101;
	localparam logic [2:0]  F_OR      = 3'b110;
	localparam logic [2:0]  F_AND     = 3'b111;
	// funct3 of add, sub, and, or, xor, sll, srl from the low end up.
	localparam logic [20:0] R_F3 = {F_SRL, F_SLL, F_XOR, F_OR, F_AND, F_ADD, F_ADD};

	logic        clk;
	logic        arst_n_i;
	logic [31:0] instr_i;
	logic [31:0] data_mem_i;
	logic [31:0] pc_o;
	logic        instr_rd_en_o;
	logic        mem_state_o;
	logic [31:0] addr_mem_o;
	logic [31:0] data_mem_wr_o;

	logic [31:0] rom [0:255];
	logic [31:0] ram [0:255];
	logic [31:0] store_addr [$];
	logic [31:0] store_data [$];
	logic        marker_seen;
	logic [31:0] lfsr;
	int          wr_idx;
	int          stall_cycles;
	int          checks;
	int          test_errors;
	int          error_total;
	int          tests_run;

	core #(
		.RESET_PC(RESET_PC)
	) uut (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.instr_i      (instr_i),
		.data_mem_i   (data_mem_i),
		.pc_o         (pc_o),
		.instr_rd_en_o(instr_rd_en_o),
		.mem_state_o  (mem_state_o),
		.addr_mem_o   (addr_mem_o),
		.data_mem_wr_o(data_mem_wr_o)
	);

	always #5 clk = ~clk;

	// both memories answer on the falling edge, after the registered addresses settle.
	always @(negedge clk) begin
		if (arst_n_i && mem_state_o) begin
			ram[addr_mem_o[9:2]] = data_mem_wr_o;
			store_addr.push_back(addr_mem_o);
			store_data.push_back(data_mem_wr_o);
			if (addr_mem_o == 32'(MARK_ADDR)) begin
				marker_seen = 1'b1;
			end
		end
		instr_i    = rom[pc_o[9:2]];
		data_mem_i = ram[addr_mem_o[9:2]];
	end

	// each cycle with the fetch read enable low is one held cycle.
	always @(posedge clk) begin
		if (arst_n_i && !instr_rd_en_o) begin
			stall_cycles++;
		end
	end

	// fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic emit(input logic [31:0] w);
		rom[wr_idx] = w;
		wr_idx++;
	endtask

	task automatic r_op(input logic [2:0] f3, input logic sub, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		emit({1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'h33});
	endtask

	task automatic i_op(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		emit({imm, rs1, f3, rd, 7'h13});
	endtask

	task automatic load_word(input logic [4:0] rd, input logic [11:0] addr);
		emit({addr, 5'd0, 3'b010, rd, 7'h03});
	endtask

	task automatic store_word(input logic [4:0] rs2, input logic [11:0] addr);
		emit({addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], 7'h23});
	endtask

	task automatic branch_ahead(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] off);
		emit({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63});
	endtask

	task automatic jal_to(input logic [4:0] rd, input logic [20:0] off);
		emit({off[20], off[10:1], off[11], off[19:12], rd, 7'h6f});
	endtask

	// builds a full word 11 bits at a time; x31 holds the shift amount.
	task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
		i_op(F_ADD, rd, 5'd0, {2'b00, v[31:22]});
		r_op(F_SLL, 1'b0, rd, rd, 5'd31);
		i_op(F_ADD, rd, rd, {1'b0, v[21:11]});
		r_op(F_SLL, 1'b0, rd, rd, 5'd31);
		i_op(F_ADD, rd, rd, {1'b0, v[10:0]});
	endtask

	task automatic hold_reset();
		@(negedge clk);
		arst_n_i = 1'b0;
		for (int k = 0; k < 256; k++) begin
			rom[k] = '0;
			ram[k] = {4{8'(k)}} ^ 32'h00ff_00ff;
		end
		wr_idx = int'(RESET_PC[9:2]);
		i_op(F_ADD, 5'd31, 5'd0, 12'd11);
	endtask

	task automatic run_program(input string name);
		int cycles;
		store_word(5'd0, MARK_ADDR);
		jal_to(5'd0, 21'd0);
		repeat (8) @(negedge clk);
		store_addr.delete();
		store_data.delete();
		marker_seen  = 1'b0;
		stall_cycles = 0;
		arst_n_i     = 1'b1;
		cycles       = 0;
		while (!marker_seen && cycles < 1000) begin
			@(posedge clk);
			cycles++;
		end
		if (!marker_seen) begin
			$display("%s: timed out after %0d cycles waiting for the final store", name, cycles);
			test_errors++;
		end
	endtask

	task automatic expect_store(input string name, input logic [31:0] addr,
			input logic [31:0] exp);
		int idx;
		idx = -1;
		foreach (store_addr[k]) begin
			if (idx < 0 && store_addr[k] == addr) begin
				idx = k;
			end
		end
		checks++;
		if (idx < 0) begin
			$display("%s: no store to address %h was seen", name, addr);
			test_errors++;
		end else if (store_data[idx] !== exp) begin
			$display("error %s: address %h expected %h actual %h", name, addr, exp,
					store_data[idx]);
			test_errors++;
		end
	endtask

	task automatic expect_no_store(input string name, input logic [31:0] addr);
		checks++;
		foreach (store_addr[k]) begin
			if (store_addr[k] == addr || store_data[k] == 32'(POISON)) begin
				$display("%s: skipped store to %h was executed", name, store_addr[k]);
				test_errors++;
			end
		end
	endtask

	task automatic expect_stalls(input string name, input int exp);
		checks++;
		if (stall_cycles != exp) begin
			$display("error %s: stall cycles expected %0d actual %0d", name, exp,
					stall_cycles);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %s finished with %0d errors", name, test_errors);
		error_total += test_errors;
		tests_run++;
		test_errors = 0;
	endtask

	task automatic alu_ops();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [31:0] imm_x;
		logic [31:0] exp;
		hold_reset();
		random_bits(32, a);
		random_bits(32, b);
		random_bits(12, r);
		imm_x = {{20{r[11]}}, r[11:0]};
		load_const(5'd1, a);
		load_const(5'd2, b);
		for (int k = 0; k < 7; k++) begin
			r_op(R_F3[3*k +: 3], k == 1, 5'd3, 5'd1, 5'd2);
			store_word(5'd3, 12'h100 + 12'(4 * k));
		end
		i_op(F_AND, 5'd3, 5'd1, r[11:0]);
		store_word(5'd3, 12'h120);
		i_op(F_OR, 5'd3, 5'd1, r[11:0]);
		store_word(5'd3, 12'h124);
		i_op(F_XOR, 5'd3, 5'd1, r[11:0]);
		store_word(5'd3, 12'h128);
		i_op(F_ADD, 5'd3, 5'd1, r[11:0]);
		store_word(5'd3, 12'h12c);
		run_program("alu_ops");
		for (int k = 0; k < 7; k++) begin
			case (k)
				0: exp = a + b;
				1: exp = a - b;
				2: exp = a & b;
				3: exp = a | b;
				4: exp = a ^ b;
				5: exp = a << b[4:0];
				default: exp = a >> b[4:0];
			endcase
			expect_store("alu_ops", 32'h100 + 32'(4 * k), exp);
		end
		expect_store("alu_ops", 32'h120, a & imm_x);
		expect_store("alu_ops", 32'h124, a | imm_x);
		expect_store("alu_ops", 32'h128, a ^ imm_x);
		expect_store("alu_ops", 32'h12c, a + imm_x);
		finish_test("alu_ops");
	endtask

	task automatic bypass();
		logic [31:0] a;
		hold_reset();
		random_bits(32, a);
		load_const(5'd1, a);
		r_op(F_ADD, 1'b0, 5'd2, 5'd1, 5'd1);
		r_op(F_ADD, 1'b1, 5'd3, 5'd2, 5'd1);
		r_op(F_XOR, 1'b0, 5'd4, 5'd2, 5'd3);
		r_op(F_OR, 1'b0, 5'd5, 5'd4, 5'd2);
		store_word(5'd5, 12'h140);
		store_word(5'd4, 12'h144);
		store_word(5'd3, 12'h148);
		store_word(5'd2, 12'h14c);
		run_program("bypass");
		expect_store("bypass", 32'h140, ((a + a) ^ a) | (a + a));
		expect_store("bypass", 32'h144, (a + a) ^ a);
		expect_store("bypass", 32'h148, a);
		expect_store("bypass", 32'h14c, a + a);
		finish_test("bypass");
	endtask

	task automatic load_use();
		logic [31:0] a;
		logic [31:0] b;
		hold_reset();
		random_bits(32, a);
		random_bits(32, b);
		load_const(5'd1, a);
		load_const(5'd2, b);
		store_word(5'd1, 12'h200);
		store_word(5'd2, 12'h204);
		load_word(5'd3, 12'h200);
		load_word(5'd4, 12'h204);
		r_op(F_ADD, 1'b0, 5'd5, 5'd3, 5'd4);
		store_word(5'd5, 12'h208);
		load_word(5'd6, 12'h204);
		store_word(5'd6, 12'h20c);
		run_program("load_use");
		expect_store("load_use", 32'h208, a + b);
		expect_store("load_use", 32'h20c, b);
		// two load-use pairs, each holding fetch for one cycle.
		expect_stalls("load_use", 2);
		finish_test("load_use");
	endtask

	task automatic branches();
		logic [31:0] a;
		hold_reset();
		random_bits(32, a);
		load_const(5'd1, a);
		i_op(F_ADD, 5'd2, 5'd1, 12'd0);
		i_op(F_ADD, 5'd3, 5'd1, 12'd1);
		i_op(F_ADD, 5'd7, 5'd0, POISON);
		branch_ahead(3'b000, 5'd1, 5'd2, 13'd8);
		store_word(5'd7, 12'h300);
		store_word(5'd1, 12'h304);
		branch_ahead(3'b000, 5'd1, 5'd3, 13'd8);
		store_word(5'd3, 12'h308);
		branch_ahead(3'b001, 5'd1, 5'd3, 13'd8);
		store_word(5'd7, 12'h30c);
		branch_ahead(3'b001, 5'd1, 5'd2, 13'd8);
		store_word(5'd2, 12'h310);
		run_program("branches");
		expect_no_store("branches", 32'h300);
		expect_no_store("branches", 32'h30c);
		expect_store("branches", 32'h304, a);
		expect_store("branches", 32'h308, a + 1);
		expect_store("branches", 32'h310, a);
		expect_stalls("branches", 0);
		finish_test("branches");
	endtask

	task automatic jal_link();
		logic [31:0] link;
		hold_reset();
		i_op(F_ADD, 5'd7, 5'd0, POISON);
		link = (32'(wr_idx) << 2) + 32'd4;
		jal_to(5'd5, 21'd12);
		store_word(5'd7, 12'h380);
		store_word(5'd7, 12'h384);
		store_word(5'd5, 12'h388);
		run_program("jal_link");
		expect_no_store("jal_link", 32'h380);
		expect_no_store("jal_link", 32'h384);
		expect_store("jal_link", 32'h388, link);
		finish_test("jal_link");
	endtask

	task automatic x0_write();
		hold_reset();
		i_op(F_ADD, 5'd1, 5'd0, 12'h123);
		i_op(F_ADD, 5'd0, 5'd0, 12'h7ff);
		r_op(F_ADD, 1'b0, 5'd0, 5'd1, 5'd1);
		load_word(5'd0, 12'h204);
		store_word(5'd0, 12'h390);
		store_word(5'd1, 12'h394);
		run_program("x0_write");
		expect_store("x0_write", 32'h390, 32'h0);
		expect_store("x0_write", 32'h394, 32'h123);
		finish_test("x0_write");
	endtask

	initial begin
		clk          = 1'b0;
		arst_n_i     = 1'b0;
		instr_i      = '0;
		data_mem_i   = '0;
		lfsr         = 32'hc228d511;
		stall_cycles = 0;
		checks       = 0;
		test_errors  = 0;
		error_total  = 0;
		tests_run    = 0;
		alu_ops();
		bypass();
		load_use();
		branches();
		jal_link();
		x0_write();
		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d", tests_run,
				checks, error_total, uut.core_checks.fail_count);
		if (error_total == 0 && uut.core_checks.fail_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
